//--- cpu900_defines.svh
/*
  Global sizing macros for the cpu900 core.
  Include this header wherever address, data or register-count widths
  are needed; the include guard makes repeated inclusion harmless.
*/
`ifndef CPU900_DEFINES_SVH
`define CPU900_DEFINES_SVH

// RAM word address width
`define CPU900_AW       24
// Data path and register width
`define CPU900_DW       16
// Number of general registers
`define CPU900_NREGS    8
// First instruction address after reset
`define CPU900_RESET_PC 0

`endif

//--- cpu900_pkg.sv
/*
  Shared types for the cpu900 core: instruction word layouts,
  opcode and ALU operation encodings, flags and register write control.
*/
`include "cpu900_defines.svh"

package cpu900_pkg;

    // Major opcode in bits 15..12
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_LDI  = 4'h1,
        OP_ADD  = 4'h2,
        OP_SUB  = 4'h3,
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_XOR  = 4'h6,
        OP_ADDI = 4'h7,
        OP_LD   = 4'h8,
        OP_ST   = 4'h9,
        OP_JR   = 4'hA,
        OP_HALT = 4'hF
    } opcode_e;

    // Register form: rd, rs
    typedef struct packed {
        opcode_e     op;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [5:0]  unused;
    } instr_reg_t;

    // Immediate form: rd or condition code, imm8
    typedef struct packed {
        opcode_e     op;
        logic [2:0]  rd;
        logic        unused;
        logic [7:0]  imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t  rf;
        instr_imm_t  imf;
    } instr_u;

    // Bit 2 low is the adder group, where bit 0 picks the immediate operand
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_ADDI = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_PASS = 3'b011,
        ALU_AND  = 3'b100,
        ALU_OR   = 3'b101,
        ALU_XOR  = 3'b110
    } alu_op_e;

    typedef struct packed {
        logic z;
        logic c;
    } flags_t;

    typedef struct packed {
        logic                              we;
        logic [$clog2(`CPU900_NREGS)-1:0]  sel;
        logic                              src;  // 1 selects memory data
    } reg_wr_t;

endpackage

//--- cpu900_ctrl.sv
/*
  Instruction sequencer and decoder.
  Runs FETCH, DECODE, MEM and HALT. In DECODE the instruction is taken
  straight from the RAM output so single-word operations finish in two
  enabled cycles; LD and ST continue into MEM.
*/
`timescale 1ns/1ns
`include "cpu900_defines.svh"

module cpu900_ctrl (
    input                                     clk,
    input                                     arst_n,
    input                                     cen,
    input        [`CPU900_DW-1:0]             ram_dout,
    input  cpu900_pkg::flags_t                flags,
    output logic [$clog2(`CPU900_NREGS)-1:0]  rd_sel,
    output logic [$clog2(`CPU900_NREGS)-1:0]  rs_sel,
    output cpu900_pkg::reg_wr_t               reg_wr,
    output cpu900_pkg::alu_op_e               alu_op,
    output logic [7:0]                        imm,
    output logic                              alu_go,
    output logic                              flag_we,
    output logic                              addr_sel,
    output logic                              mem_wr,
    output logic                              latch_en,
    output logic                              pc_inc,
    output logic                              pc_jump,
    output logic [7:0]                        disp,
    output logic                              halted
);
    import cpu900_pkg::*;

    typedef enum logic [1:0] {S_FETCH, S_DECODE, S_MEM, S_HALT} state_e;

    state_e  state;
    logic    mem_wb;
    instr_u  ir;
    instr_u  cur;
    opcode_e op;
    logic    in_decode;
    logic    in_mem;
    logic    alu_wr;
    logic    cond_ok;

    // RAM output carries the instruction during DECODE only
    always_comb begin
        if (state == S_DECODE) begin
            cur = ram_dout;
        end else begin
            cur = ir;
        end
    end

    assign op        = cur.rf.op;
    assign in_decode = (state == S_DECODE);
    assign in_mem    = (state == S_MEM);

    always_comb begin
        alu_wr  = 1'b1;
        flag_we = 1'b1;
        case (op)
            OP_LDI:  begin alu_op = ALU_PASS; flag_we = 1'b0; end
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_ADDI: alu_op = ALU_ADDI;
            default: begin alu_op = ALU_PASS; alu_wr = 1'b0; flag_we = 1'b0; end
        endcase
    end

    // JR condition code sits in the rd field
    always_comb begin
        case (cur.imf.rd)
            3'd0:    cond_ok = 1'b1;
            3'd1:    cond_ok = flags.z;
            3'd2:    cond_ok = !flags.z;
            3'd3:    cond_ok = flags.c;
            3'd4:    cond_ok = !flags.c;
            default: cond_ok = 1'b0;
        endcase
    end

    assign rd_sel     = cur.rf.rd;
    assign rs_sel     = cur.rf.rs;
    assign imm        = cur.imf.imm;
    assign disp       = cur.imf.imm;
    assign alu_go     = in_decode && alu_wr;
    assign reg_wr.we  = (in_decode && alu_wr) || (in_mem && mem_wb);
    assign reg_wr.sel = cur.rf.rd;
    assign reg_wr.src = in_mem;
    assign addr_sel   = in_mem;
    assign mem_wr     = in_mem && (op == OP_ST);
    assign latch_en   = in_mem && mem_wb;
    assign pc_inc     = (state == S_FETCH);
    assign pc_jump    = in_decode && (op == OP_JR) && cond_ok;
    assign halted     = (state == S_HALT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= S_FETCH;
            mem_wb <= 1'b0;
            ir     <= '0;
        end else if (cen) begin
            case (state)
                S_FETCH: state <= S_DECODE;
                S_DECODE: begin
                    ir <= cur;
                    if (op == OP_LD || op == OP_ST) begin
                        state <= S_MEM;
                    end else if (op == OP_HALT) begin
                        state <= S_HALT;
                    end else begin
                        state <= S_FETCH;
                    end
                end
                S_MEM: begin
                    // LD spends a second step waiting for the read word
                    if (op == OP_LD && !mem_wb) begin
                        mem_wb <= 1'b1;
                    end else begin
                        mem_wb <= 1'b0;
                        state  <= S_FETCH;
                    end
                end
                default: state <= S_HALT;
            endcase
        end
    end

endmodule

//--- cpu900_regs.sv
/*
  General register bank, eight 16-bit registers.
  Two combinational read ports feed the ALU and memory path, one write
  port takes ALU or memory data, and a third read port serves the
  external register dump.
*/
`timescale 1ns/1ns
`include "cpu900_defines.svh"

module cpu900_regs (
    input                                     clk,
    input                                     arst_n,
    input                                     cen,
    input        [$clog2(`CPU900_NREGS)-1:0]  rd_sel,
    input        [$clog2(`CPU900_NREGS)-1:0]  rs_sel,
    input  cpu900_pkg::reg_wr_t               reg_wr,
    input        [`CPU900_DW-1:0]             alu_result,
    input        [`CPU900_DW-1:0]             mem_data,
    input        [$clog2(`CPU900_NREGS)-1:0]  dmp_addr,
    output logic [`CPU900_DW-1:0]             rd_val,
    output logic [`CPU900_DW-1:0]             rs_val,
    output logic [`CPU900_DW-1:0]             dmp_din
);

    logic [`CPU900_DW-1:0] regs [`CPU900_NREGS];
    logic [`CPU900_DW-1:0] wdata;

    assign wdata = reg_wr.src ? mem_data : alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU900_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (cen && reg_wr.we) begin
            regs[reg_wr.sel] <= wdata;
        end
    end

    // Operand reads
    assign rd_val  = regs[rd_sel];
    assign rs_val  = regs[rs_sel];

    // Dump read, independent of the core
    assign dmp_din = regs[dmp_addr];

endmodule

//--- cpu900_alu.sv
/*
  Arithmetic and logic unit with the Z and C flag register.
  The result is combinational from the operands; flags update on an
  enabled edge when the controller strobes go with flag_we set.
*/
`timescale 1ns/1ns
`include "cpu900_defines.svh"

module cpu900_alu (
    input                               clk,
    input                               arst_n,
    input                               cen,
    input  cpu900_pkg::alu_op_e         op,
    input        [`CPU900_DW-1:0]       a,
    input        [`CPU900_DW-1:0]       b,
    input        [7:0]                  imm,
    input                               go,
    input                               flag_we,
    output logic [`CPU900_DW-1:0]       result,
    output cpu900_pkg::flags_t          flags
);
    import cpu900_pkg::*;

    logic                  use_imm;
    logic [`CPU900_DW-1:0] opb;
    logic [`CPU900_DW:0]   sum;
    logic [`CPU900_DW:0]   diff;
    logic                  carry;

    // Immediate replaces b for ADDI and pass
    assign use_imm = !op[2] && op[0];
    assign opb     = use_imm ? {{(`CPU900_DW-8){1'b0}}, imm} : b;

    assign sum  = {1'b0, a} + {1'b0, opb};
    assign diff = {1'b0, a} - {1'b0, opb};

    always_comb begin
        carry = 1'b0;
        case (op)
            ALU_ADD, ALU_ADDI: begin
                result = sum[`CPU900_DW-1:0];
                carry  = sum[`CPU900_DW];
            end
            ALU_SUB: begin
                result = diff[`CPU900_DW-1:0];
                carry  = diff[`CPU900_DW];   // borrow
            end
            ALU_AND: result = a & opb;
            ALU_OR:  result = a | opb;
            ALU_XOR: result = a ^ opb;
            default: result = opb;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags <= '0;
        end else if (cen && go && flag_we) begin
            flags.z <= (result == '0);
            flags.c <= carry;
        end
    end

endmodule

//--- cpu900_ramctl.sv
/*
  Memory controller between the core and the synchronous RAM.
  Selects the PC or a zero-extended data address, drives write data
  and the gated write strobe, and holds the last word read for LD.
*/
`timescale 1ns/1ns
`include "cpu900_defines.svh"

module cpu900_ramctl (
    input                          clk,
    input                          arst_n,
    input                          cen,
    input        [`CPU900_AW-1:0]  pc,
    input        [`CPU900_DW-1:0]  data_addr,
    input        [`CPU900_DW-1:0]  wr_data,
    input                          addr_sel,
    input                          mem_wr,
    input                          latch_en,
    input        [`CPU900_DW-1:0]  ram_dout,
    output logic [`CPU900_AW-1:0]  ram_addr,
    output logic [`CPU900_DW-1:0]  ram_din,
    output logic [1:0]             ram_we,
    output logic [`CPU900_DW-1:0]  latched
);

    logic [`CPU900_DW-1:0] data_q;

    assign ram_addr = addr_sel ? {{(`CPU900_AW-`CPU900_DW){1'b0}}, data_addr} : pc;
    assign ram_din  = wr_data;

    // Both byte lanes, only on enabled cycles
    assign ram_we   = {2{mem_wr & cen}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_q <= '0;
        end else if (cen && latch_en) begin
            data_q <= ram_dout;
        end
    end

    // Read word goes through while it is being captured,
    // so the register write lands on the same edge
    assign latched = latch_en ? ram_dout : data_q;

endmodule

//--- cpu900_pc.sv
/*
  Program counter.
  Steps by one word on inc and adds the sign-extended 8-bit
  displacement on jump.
*/
`timescale 1ns/1ns
`include "cpu900_defines.svh"

module cpu900_pc (
    input                          clk,
    input                          arst_n,
    input                          cen,
    input                          inc,
    input                          jump,
    input        [7:0]             disp,
    output logic [`CPU900_AW-1:0]  pc
);

    logic [`CPU900_AW-1:0] disp_ext;

    assign disp_ext = {{(`CPU900_AW-8){disp[7]}}, disp};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `CPU900_AW'(`CPU900_RESET_PC);
        end else if (cen) begin
            if (jump) begin
                pc <= pc + disp_ext;
            end else if (inc) begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

//--- cpu900.sv
/*
  cpu900 top level, a small 16-bit core.
  Connects the controller, register bank, ALU, memory controller and
  program counter to an external synchronous RAM and a register dump
  port. All state advances on rising clk edges with cen high.
*/
`timescale 1ns/1ns
`include "cpu900_defines.svh"

module cpu900 (
    input                                      clk,
    input                                      arst_n,
    input                                      cen,

    output        [`CPU900_AW-1:0]             ram_addr,
    input         [`CPU900_DW-1:0]             ram_dout,
    output        [`CPU900_DW-1:0]             ram_din,
    output        [1:0]                        ram_we,
    // Register dump
    input         [$clog2(`CPU900_NREGS)-1:0]  dmp_addr,
    output        [`CPU900_DW-1:0]             dmp_din,
    output                                     halted
);
    import cpu900_pkg::*;

    // Register bank
    logic [$clog2(`CPU900_NREGS)-1:0] rd_sel, rs_sel;
    reg_wr_t                          reg_wr;
    logic [`CPU900_DW-1:0]            rd_val, rs_val;

    // ALU
    alu_op_e               alu_op;
    logic [7:0]            imm;
    logic                  alu_go, flag_we;
    logic [`CPU900_DW-1:0] alu_result;
    flags_t                flags;

    // Memory and PC
    logic                  addr_sel, mem_wr, latch_en;
    logic [`CPU900_DW-1:0] latched;
    logic                  pc_inc, pc_jump;
    logic [7:0]            disp;
    logic [`CPU900_AW-1:0] pc;

    cpu900_ctrl u_ctrl (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cen        ( cen        ),
        .ram_dout   ( ram_dout   ),
        .flags      ( flags      ),
        .rd_sel     ( rd_sel     ),
        .rs_sel     ( rs_sel     ),
        .reg_wr     ( reg_wr     ),
        .alu_op     ( alu_op     ),
        .imm        ( imm        ),
        .alu_go     ( alu_go     ),
        .flag_we    ( flag_we    ),
        .addr_sel   ( addr_sel   ),
        .mem_wr     ( mem_wr     ),
        .latch_en   ( latch_en   ),
        .pc_inc     ( pc_inc     ),
        .pc_jump    ( pc_jump    ),
        .disp       ( disp       ),
        .halted     ( halted     )
    );

    cpu900_regs u_regs (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cen        ( cen        ),
        .rd_sel     ( rd_sel     ),
        .rs_sel     ( rs_sel     ),
        .reg_wr     ( reg_wr     ),
        .alu_result ( alu_result ),
        .mem_data   ( latched    ),
        .dmp_addr   ( dmp_addr   ),
        .rd_val     ( rd_val     ),
        .rs_val     ( rs_val     ),
        .dmp_din    ( dmp_din    )
    );

    cpu900_alu u_alu (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cen        ( cen        ),
        .op         ( alu_op     ),
        .a          ( rd_val     ),
        .b          ( rs_val     ),
        .imm        ( imm        ),
        .go         ( alu_go     ),
        .flag_we    ( flag_we    ),
        .result     ( alu_result ),
        .flags      ( flags      )
    );

    cpu900_ramctl u_ramctl (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cen        ( cen        ),
        .pc         ( pc         ),
        .data_addr  ( rs_val     ),
        .wr_data    ( rd_val     ),
        .addr_sel   ( addr_sel   ),
        .mem_wr     ( mem_wr     ),
        .latch_en   ( latch_en   ),
        .ram_dout   ( ram_dout   ),
        .ram_addr   ( ram_addr   ),
        .ram_din    ( ram_din    ),
        .ram_we     ( ram_we     ),
        .latched    ( latched    )
    );

    cpu900_pc u_pc (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cen        ( cen        ),
        .inc        ( pc_inc     ),
        .jump       ( pc_jump    ),
        .disp       ( disp       ),
        .pc         ( pc         )
    );

endmodule

//--- cpu900_asserts.sv
/*
  Concurrent checks on the cpu900 controller sequencing.
  Bound into cpu900_ctrl; covers the RAM write strobe, the halted
  level and the exclusive PC controls.
*/
`timescale 1ns/1ns

module cpu900_asserts (
    input                         clk,
    input                         arst_n,
    input                         cen,
    input        [1:0]            state,
    input  cpu900_pkg::opcode_e   op,
    input                         mem_wr,
    input                         pc_inc,
    input                         pc_jump,
    input                         halted
);
    import cpu900_pkg::*;

    // MEM in the controller's state order
    localparam logic [1:0] MEM_STATE = 2'd2;

    // Number of failed properties
    int unsigned fail_count = 0;

    // Write strobe only in MEM for ST
    store_in_mem: assert property (@(posedge clk) disable iff (!arst_n)
        (cen && mem_wr) |-> (state == MEM_STATE && op == OP_ST))
        else begin
            $error("RAM write strobe outside MEM for ST");
            fail_count++;
        end

    // One enabled write, then the strobe drops
    single_write: assert property (@(posedge clk) disable iff (!arst_n)
        (cen && mem_wr) |=> !mem_wr)
        else begin
            $error("RAM write strobe held for two enabled cycles");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted)
        else begin
            $error("halted fell before reset");
            fail_count++;
        end

    pc_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(pc_inc && pc_jump))
        else begin
            $error("pc_inc and pc_jump high together");
            fail_count++;
        end

endmodule

//--- tb_cpu900.sv
/*
  Testbench for the cpu900 core.
  Builds a random program from a fixed seed, runs it with a random
  clock enable against a RAM model and compares RAM writes, the fetch
  trace and the final registers with an instruction-set model.
*/
`timescale 1ns/1ns
`include "cpu900_defines.svh"

module tb_cpu900;
    import cpu900_pkg::*;

    localparam int PROG_LEN       = 60;
    localparam int HALT_ADDR      = PROG_LEN;
    localparam int TIMEOUT_CYCLES = 61 * 4 * 4 + 8 + 4;

    logic                   clk;
    logic                   arst_n;
    logic                   cen;
    logic [`CPU900_DW-1:0]  ram_dout;
    logic [2:0]             dmp_addr;
    logic [`CPU900_AW-1:0]  ram_addr;
    logic [`CPU900_DW-1:0]  ram_din;
    logic [1:0]             ram_we;
    logic [`CPU900_DW-1:0]  dmp_din;
    logic                   halted;

    logic [31:0]            rng_state = 32'd63784;
    logic [15:0]            dut_mem [65536];
    logic [15:0]            ref_mem [65536];
    logic [15:0]            ref_regs [8];
    // Expected writes as {address, data}
    logic [39:0]            exp_writes [$];
    int                     exp_pcs [$];

    cpu900 cpu900_inst (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .cen      ( cen      ),
        .ram_addr ( ram_addr ),
        .ram_dout ( ram_dout ),
        .ram_din  ( ram_din  ),
        .ram_we   ( ram_we   ),
        .dmp_addr ( dmp_addr ),
        .dmp_din  ( dmp_din  ),
        .halted   ( halted   )
    );

    bind cpu900_ctrl cpu900_asserts asserts_inst (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .cen     ( cen     ),
        .state   ( state   ),
        .op      ( op      ),
        .mem_wr  ( mem_wr  ),
        .pc_inc  ( pc_inc  ),
        .pc_jump ( pc_jump ),
        .halted  ( halted  )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic end_in_failure();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic explain_failure(input string what);
        $display("%s", what);
        end_in_failure();
    endtask

    task automatic show_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
        end_in_failure();
    endtask

    task automatic build_program();
        logic [31:0] r;
        opcode_e     op;
        logic [2:0]  rd;
        logic [2:0]  rs;
        int          cc;
        int          disp;
        for (int a = 0; a < 65536; a++) begin
            r = next_rand();
            // Low area holds the program and the store window
            dut_mem[a] = (a < 256) ? 16'h0000 : r[15:0];
        end
        for (int a = 0; a < PROG_LEN; a++) begin
            r    = next_rand();
            op   = opcode_e'(4'(r[31:24] % 11));
            rd   = 3'(r[23:16] % 6);
            rs   = r[15:13];
            cc   = int'(r[15:13]) % 5;
            disp = int'((r >> 8) % (PROG_LEN - a));
            case (op)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LD:
                    dut_mem[a] = {op, rd, rs, 6'b0};
                // Data from any register and address from r6 or r7
                OP_ST:
                    dut_mem[a] = {op, rs, {2'b11, r[3]}, 6'b0};
                // Forward only and never past the HALT
                OP_JR:
                    dut_mem[a] = {op, 3'(cc), 1'b0, 8'(disp)};
                default:
                    dut_mem[a] = {op, rd, 1'b0, r[7:0]};
            endcase
        end
        // r6 and r7 become store pointers in 64..255 above the program
        r = next_rand();
        dut_mem[0]         = {OP_LDI, 3'd6, 1'b0, r[7:0] | 8'h40};
        dut_mem[1]         = {OP_LDI, 3'd7, 1'b0, r[15:8] | 8'h40};
        dut_mem[HALT_ADDR] = {OP_HALT, 12'h000};
        ref_mem = dut_mem;
    endtask

    // Instruction-set model without cycles or cen
    task automatic run_model();
        int          pc;
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic        z;
        logic        c;
        logic        take;
        logic        done;
        pc   = `CPU900_RESET_PC;
        z    = 1'b0;
        c    = 1'b0;
        done = 1'b0;
        for (int i = 0; i < 8; i++) begin
            ref_regs[i] = '0;
        end
        while (!done) begin
            w = ref_mem[pc];
            exp_pcs.push_back(pc);
            pc++;
            a = ref_regs[w[11:9]];
            b = ref_regs[w[8:6]];
            case (w[15:12])
                OP_LDI: ref_regs[w[11:9]] = {8'h00, w[7:0]};
                OP_ADD, OP_ADDI, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                    if (w[15:12] == OP_ADDI) begin
                        b = {8'h00, w[7:0]};
                    end
                    c = 1'b0;
                    case (w[15:12])
                        OP_SUB: begin
                            res = a - b;
                            c   = (a < b);
                        end
                        OP_AND: res = a & b;
                        OP_OR:  res = a | b;
                        OP_XOR: res = a ^ b;
                        default: begin
                            res = a + b;
                            c   = (int'(a) + int'(b) > 65535);
                        end
                    endcase
                    z = (res == 16'h0000);
                    ref_regs[w[11:9]] = res;
                end
                OP_LD: ref_regs[w[11:9]] = ref_mem[b];
                OP_ST: begin
                    ref_mem[b] = a;
                    exp_writes.push_back({8'h00, b, a});
                end
                OP_JR: begin
                    case (w[11:9])
                        3'd0:    take = 1'b1;
                        3'd1:    take = z;
                        3'd2:    take = !z;
                        3'd3:    take = c;
                        3'd4:    take = !c;
                        default: take = 1'b0;
                    endcase
                    if (take) begin
                        pc = pc + int'($signed(w[7:0]));
                    end
                end
                OP_HALT: done = 1'b1;
                default: ;
            endcase
        end
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * 10);
        explain_failure($sformatf("Timeout: the core did not halt within %0d clock cycles",
                                  TIMEOUT_CYCLES));
    end

    initial begin
        logic        s_cen;
        logic        p_cen;
        logic        s_inc;
        logic        s_halt;
        logic        have_prev;
        logic [23:0] s_addr;
        logic [23:0] p_addr;
        logic [1:0]  s_we;
        logic [15:0] s_din;
        logic [15:0] s_dmp;
        logic [15:0] p_dmp;
        logic [39:0] w_exp;
        int          pc_exp;

        arst_n   = 1'b0;
        cen      = 1'b0;
        ram_dout = '0;
        dmp_addr = '0;
        build_program();
        run_model();

        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Reset state with cen high between two edges
        cen = 1'b1;
        for (int i = 0; i < 8; i++) begin
            dmp_addr = 3'(i);
            #1;
            assert (dmp_din == '0)
                else show_mismatch($sformatf("dmp_din (r%0d)", i), dmp_din, 0);
        end
        assert (ram_we == 2'b00) else show_mismatch("ram_we", ram_we, 0);
        assert (halted == 1'b0) else show_mismatch("halted", halted, 0);
        cen = 1'b0;

        @(posedge clk);
        #1;
        dmp_addr  = '0;
        cen       = (next_rand() % 4) != 0;
        have_prev = 1'b0;
        s_halt    = 1'b0;

        while (!s_halt) begin
            // Mid-cycle sample equal to what the next edge sees
            @(negedge clk);
            s_cen  = cen;
            s_addr = ram_addr;
            s_we   = ram_we;
            s_din  = ram_din;
            s_inc  = cpu900_inst.u_ctrl.pc_inc;
            s_halt = halted;
            s_dmp  = dmp_din;
            assert (cpu900_inst.u_ctrl.asserts_inst.fail_count == 0)
                else explain_failure("A bound assertion on the controller failed");
            if (!s_cen) begin
                assert (s_we == 2'b00) else show_mismatch("ram_we", s_we, 0);
            end
            // Nothing may move across a disabled edge
            if (have_prev && !p_cen) begin
                assert (s_addr == p_addr) else show_mismatch("ram_addr", s_addr, p_addr);
                assert (s_dmp == p_dmp) else show_mismatch("dmp_din", s_dmp, p_dmp);
            end
            p_cen     = s_cen;
            p_addr    = s_addr;
            p_dmp     = s_dmp;
            have_prev = 1'b1;

            @(posedge clk);
            #1;
            if (s_cen) begin
                if (s_we != 2'b00) begin
                    assert (exp_writes.size() > 0)
                        else explain_failure("RAM write with no write left in the model");
                    w_exp = exp_writes.pop_front();
                    assert (s_we == 2'b11) else show_mismatch("ram_we", s_we, 2'b11);
                    assert (s_addr == w_exp[39:16])
                        else show_mismatch("ram_addr", s_addr, w_exp[39:16]);
                    assert (s_din == w_exp[15:0])
                        else show_mismatch("ram_din", s_din, w_exp[15:0]);
                    dut_mem[s_addr[15:0]] = s_din;
                end
                if (s_inc) begin
                    assert (exp_pcs.size() > 0)
                        else explain_failure("Fetch after the model's last instruction");
                    pc_exp = exp_pcs.pop_front();
                    assert (s_addr == 24'(pc_exp))
                        else show_mismatch("ram_addr (fetch)", s_addr, pc_exp);
                end
                ram_dout = dut_mem[s_addr[15:0]];
                dmp_addr = dmp_addr + 1'b1;
            end
            cen = s_halt ? 1'b0 : ((next_rand() % 4) != 0);
        end

        // Final registers through the dump port
        for (int i = 0; i < 8; i++) begin
            dmp_addr = 3'(i);
            #1;
            assert (dmp_din == ref_regs[i])
                else show_mismatch($sformatf("dmp_din (r%0d)", i), dmp_din, ref_regs[i]);
        end
        assert (exp_writes.size() == 0)
            else explain_failure("The core halted before making every RAM write of the model");
        assert (exp_pcs.size() == 0)
            else explain_failure("The core halted before fetching every model instruction");

        if (cpu900_inst.u_ctrl.asserts_inst.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            explain_failure("A bound assertion on the controller failed");
        end
    end

endmodule

//--- cpu900.f
+incdir+.
cpu900_pkg.sv
cpu900_ctrl.sv
cpu900_regs.sv
cpu900_alu.sv
cpu900_ramctl.sv
cpu900_pc.sv
cpu900.sv
cpu900_asserts.sv
tb_cpu900.sv
